// ==== files.f ====
hdl/uart_frame_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/tx_string_latch.sv
hdl/rx_string_assembler.sv
hdl/frame_ctrl.sv
hdl/uart_string_top.sv
tb/tb_uart_string.sv

// ==== hdl/frame_ctrl.sv ====
/*
 * Framing controller.
 * Transmit FSM wraps the payload in "&&" markers byte by byte.
 * Receive FSM finds "&&payload&&" frames and feeds the assembler.
 */
`timescale 1ns/1ns
`default_nettype none

module frame_ctrl (
	input  wire                              sys_clk,
	input  wire                              sys_rst_n,
	input  wire                              tx_req,
	output logic                             tx_busy,
	output logic                             tx_done,
	output logic                             capture,
	output logic [uart_frame_pkg::len_w-1:0] index,
	input  wire  [7:0]                       cur_byte,
	input  wire                              last,
	output logic                             byte_req,
	output logic [7:0]                       byte_data,
	input  wire                              byte_done,
	input  wire  [7:0]                       rx_byte,
	input  wire                              rx_vld,
	output logic                             rx_busy,
	output logic                             rx_done,
	output logic                             clear,
	output logic                             wr_en,
	output logic [7:0]                       wr_byte
);
	import uart_frame_pkg::*;

	logic [tx_st_w-1:0] tx_state;
	logic [rx_st_w-1:0] rx_state;
	logic               is_mark;

	assign tx_busy = (tx_state != ts_idle);
	assign tx_done = (tx_state == ts_finish);
	assign capture = (tx_state == ts_idle) && tx_req;
	assign byte_data = (tx_state == ts_data) ? cur_byte : frame_mark;

	// Each state sends one byte, byte_req follows the previous byte_done.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= ts_idle;
			index <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (tx_state)
				ts_idle: begin
					index <= '0;
					if (tx_req) begin
						byte_req <= 1'b1;
						tx_state <= ts_open1;
					end
				end
				ts_open1: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						tx_state <= ts_open2;
					end
				end
				ts_open2: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						tx_state <= ts_data;
					end
				end
				ts_data: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (last)
							tx_state <= ts_close1;
						else
							index <= index + len_w'(1);
					end
				end
				ts_close1: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						tx_state <= ts_close2;
					end
				end
				ts_close2: begin
					if (byte_done)
						tx_state <= ts_finish;
				end
				ts_finish: tx_state <= ts_idle;
				default: tx_state <= ts_idle;
			endcase
		end
	end

	assign is_mark = (rx_byte == frame_mark);
	assign rx_busy = (rx_state != rs_idle);
	assign rx_done = (rx_state == rs_finish);

	// rx_byte holds until the next byte, so a late write still sees it.
	assign wr_byte = (rx_state == rs_split) ? frame_mark : rx_byte;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= rs_idle;
			clear <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			clear <= 1'b0;
			wr_en <= 1'b0;
			case (rx_state)
				rs_idle: begin
					if (rx_vld && is_mark)
						rx_state <= rs_open;
				end
				rs_open: begin
					if (rx_vld && is_mark) begin
						clear <= 1'b1; // Frame opened.
						rx_state <= rs_payload;
					end else if (rx_vld) begin
						rx_state <= rs_idle;
					end
				end
				rs_payload: begin
					if (rx_vld && is_mark)
						rx_state <= rs_pend;
					else if (rx_vld)
						wr_en <= 1'b1;
				end
				rs_pend: begin
					if (rx_vld && is_mark) begin
						rx_state <= rs_finish;
					end else if (rx_vld) begin
						wr_en <= 1'b1; // Lone mark is data.
						rx_state <= rs_split;
					end
				end
				rs_split: begin
					wr_en <= 1'b1;
					rx_state <= rs_payload;
				end
				rs_finish: rx_state <= rs_idle;
				default: rx_state <= rs_idle;
			endcase
		end
	end

	// A frame ends only through the done pulse.
	a_busy_falls_after_done : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_busy) |-> $past(tx_done)
	) else $error("tx_busy fell without tx_done");

endmodule

`default_nettype wire

// ==== hdl/rx_string_assembler.sv ====
/*
 * Receive string assembler.
 * Stores payload bytes in arrival order and counts them up to str_bytes.
 */
`timescale 1ns/1ns
`default_nettype none

module rx_string_assembler (
	input  wire                              sys_clk,
	input  wire                              sys_rst_n,
	input  wire                              clear,
	input  wire                              wr_en,
	input  wire  [7:0]                       wr_byte,
	output logic [uart_frame_pkg::str_w-1:0] rx_string,
	output logic [uart_frame_pkg::len_w-1:0] rx_length
);
	import uart_frame_pkg::*;

	logic room;

	assign room = (rx_length < len_w'(str_bytes));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_length <= '0;
		else if (clear)
			rx_length <= '0;
		else if (wr_en && room)
			rx_length <= rx_length + len_w'(1); // Saturates at str_bytes.
	end

	// Bytes past the end of the buffer are dropped.
	always_ff @(posedge sys_clk) begin
		if (clear)
			rx_string <= '0;
		else if (wr_en && room)
			rx_string[8*rx_length +: 8] <= wr_byte;
	end

	a_len_in_range : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= len_w'(str_bytes)
	) else $error("rx_length above str_bytes");

endmodule

`default_nettype wire

// ==== hdl/tx_string_latch.sv ====
/*
 * Transmit string holder.
 * Captures the host string and length at frame start and returns
 * the byte at the requested index.
 */
`timescale 1ns/1ns
`default_nettype none

module tx_string_latch (
	input  wire                              sys_clk,
	input  wire                              sys_rst_n,
	input  wire                              capture,
	input  wire  [uart_frame_pkg::str_w-1:0] tx_string,
	input  wire  [uart_frame_pkg::len_w-1:0] tx_length,
	input  wire  [uart_frame_pkg::len_w-1:0] index,
	output logic [7:0]                       cur_byte,
	output logic                             last
);
	import uart_frame_pkg::*;

	logic [str_w-1:0] str_q;
	logic [len_w-1:0] len_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			len_q <= '0;
		else if (capture)
			len_q <= tx_length;
	end

	// Host may change tx_string once the frame has started.
	always_ff @(posedge sys_clk) begin
		if (capture)
			str_q <= tx_string;
	end

	assign cur_byte = str_q[8*index +: 8];

	// A zero length is treated as one byte so the frame still ends.
	assign last = (index + len_w'(1)) >= len_q;

endmodule

`default_nettype wire

// ==== hdl/uart_frame_pkg.sv ====
/*
 * UART string framer constants.
 * Bit timing, string size, marker byte and the framing FSM state encodings.
 */
`default_nettype none

package uart_frame_pkg;

	localparam int clks_per_bit = 16; // Serial bit period in sys_clk cycles.
	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);

	localparam int str_bytes = 16; // Largest payload in bytes.
	localparam int len_w = 5;      // Holds 0 to 16.
	localparam int str_w = 8 * str_bytes;

	localparam logic [7:0] frame_mark = 8'h26; // ASCII "&".

	// Transmit framing states, one-hot.
	localparam int tx_st_w = 7;
	localparam logic [tx_st_w-1:0] ts_idle   = 7'b000_0001;
	localparam logic [tx_st_w-1:0] ts_open1  = 7'b000_0010;
	localparam logic [tx_st_w-1:0] ts_open2  = 7'b000_0100;
	localparam logic [tx_st_w-1:0] ts_data   = 7'b000_1000;
	localparam logic [tx_st_w-1:0] ts_close1 = 7'b001_0000;
	localparam logic [tx_st_w-1:0] ts_close2 = 7'b010_0000;
	localparam logic [tx_st_w-1:0] ts_finish = 7'b100_0000;

	// Receive framing states, one-hot.
	localparam int rx_st_w = 6;
	localparam logic [rx_st_w-1:0] rs_idle    = 6'b00_0001;
	localparam logic [rx_st_w-1:0] rs_open    = 6'b00_0010;
	localparam logic [rx_st_w-1:0] rs_payload = 6'b00_0100;
	localparam logic [rx_st_w-1:0] rs_pend    = 6'b00_1000;
	localparam logic [rx_st_w-1:0] rs_split   = 6'b01_0000;
	localparam logic [rx_st_w-1:0] rs_finish  = 6'b10_0000;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
/*
 * UART byte receiver.
 * Synchronizes the line, samples each bit at mid-period and emits
 * every byte whose stop bit reads high.
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        rxd,
	output logic [7:0] rx_byte,
	output logic       rx_vld
);
	import uart_frame_pkg::*;

	logic             rx_meta;
	logic             rx_sync;
	logic             active;
	logic [3:0]       bit_idx; // 0 start, 1..8 data, 9 stop, 10 tail.
	logic [cnt_w-1:0] baud_cnt;
	logic             half_bit;
	logic             tick;
	logic [7:0]       data_sr;

	// Start and tail phases last half a bit.
	assign half_bit = (bit_idx == 4'd0) || (bit_idx == 4'd10);
	assign tick = active && (baud_cnt == (half_bit ? cnt_half : cnt_full));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active <= 1'b0;
			bit_idx <= 4'd0;
			baud_cnt <= '0;
			rx_vld <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (!active) begin
				baud_cnt <= '0;
				bit_idx <= 4'd0;
				if (!rx_sync)
					active <= 1'b1; // Falling edge, maybe a start bit.
			end else if (tick) begin
				baud_cnt <= '0;
				case (bit_idx)
					4'd0: begin
						if (rx_sync)
							active <= 1'b0; // False start.
						else
							bit_idx <= 4'd1;
					end
					4'd9: begin
						if (rx_sync)
							bit_idx <= 4'd10;
						else
							active <= 1'b0; // Framing error, byte dropped.
					end
					4'd10: begin
						rx_vld <= 1'b1;
						active <= 1'b0;
					end
					default: bit_idx <= bit_idx + 4'd1;
				endcase
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tick && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			data_sr <= {rx_sync, data_sr[7:1]}; // LSB arrives first.
		if (tick && bit_idx == 4'd10)
			rx_byte <= data_sr;
	end

endmodule

`default_nettype wire

// ==== hdl/uart_string_top.sv ====
/*
 * UART string framer top level.
 * Ties the framing controller to the UART and string blocks.
 */
`timescale 1ns/1ns
`default_nettype none

module uart_string_top (
	input  wire                              sys_clk,
	input  wire                              sys_rst_n,
	input  wire  [uart_frame_pkg::str_w-1:0] tx_string,
	input  wire  [uart_frame_pkg::len_w-1:0] tx_length,
	input  wire                              tx_req,
	output logic                             tx_busy,
	output logic                             tx_done,
	output logic [uart_frame_pkg::str_w-1:0] rx_string,
	output logic [uart_frame_pkg::len_w-1:0] rx_length,
	output logic                             rx_busy,
	output logic                             rx_done,
	input  wire                              uart_rx_port,
	output logic                             uart_tx_port
);
	import uart_frame_pkg::*;

	logic             capture;
	logic [len_w-1:0] index;
	logic [7:0]       cur_byte;
	logic             last;
	logic             byte_req;
	logic [7:0]       byte_data;
	logic             byte_done;
	logic [7:0]       rx_byte;
	logic             rx_vld;
	logic             clear;
	logic             wr_en;
	logic [7:0]       wr_byte;

	frame_ctrl u_frame_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.capture   (capture),
		.index     (index),
		.cur_byte  (cur_byte),
		.last      (last),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.byte_done (byte_done),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.clear     (clear),
		.wr_en     (wr_en),
		.wr_byte   (wr_byte)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.txd       (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	tx_string_latch u_tx_string_latch (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.capture   (capture),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.index     (index),
		.cur_byte  (cur_byte),
		.last      (last)
	);

	rx_string_assembler u_rx_string_assembler (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.clear     (clear),
		.wr_en     (wr_en),
		.wr_byte   (wr_byte),
		.rx_string (rx_string),
		.rx_length (rx_length)
	);

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
/*
 * UART byte transmitter.
 * Sends start bit, eight data bits LSB first and one stop bit per request.
 */
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        byte_req,
	input  wire  [7:0] byte_data,
	output logic       txd,
	output logic       byte_done
);
	import uart_frame_pkg::*;

	logic             active;
	logic [3:0]       bit_idx;
	logic [cnt_w-1:0] baud_cnt;
	logic [9:0]       frame_sr; // Stop, data and start bits, sent from bit 0.
	logic             bit_end;

	assign bit_end = (baud_cnt == cnt_full);
	assign txd = frame_sr[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active <= 1'b0;
			bit_idx <= 4'd0;
			baud_cnt <= '0;
			frame_sr <= '1; // Line idles high.
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!active) begin
				if (byte_req) begin
					active <= 1'b1;
					bit_idx <= 4'd0;
					baud_cnt <= '0;
					frame_sr <= {1'b1, byte_data, 1'b0};
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				frame_sr <= {1'b1, frame_sr[9:1]};
				if (bit_idx == 4'd9) begin
					active <= 1'b0; // End of stop bit.
					byte_done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// The controller must wait for byte_done before the next request.
	a_no_req_when_active : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		active |-> !byte_req
	) else $error("uart_tx got byte_req during a byte");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the UART string framer testbench with Verilator, run it and check the log.
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_uart_string \
	-f files.f -o sim_uart_string > build.log 2>&1 \
	&& ./obj_dir/sim_uart_string > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

// ==== tb/tb_uart_string.sv ====
/*
 * Testbench for the UART string framer.
 * Random frames in loopback and from a line encoder, checked against a
 * line decoder on the transmit pin and a receive framing model.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_uart_string;
	import uart_frame_pkg::*;

	localparam int clk_ns = 40;
	localparam int bit_ns = clks_per_bit * clk_ns;
	// Worst case line bytes over 20 loopback, 4 marked, 2 overflow and 1 busy frame.
	localparam int max_line_bytes = 20 * 20 + 4 * 22 + 2 * 24 + 20;
	localparam int limit_ns = max_line_bytes * 10 * clks_per_bit * clk_ns * 2;

	logic             sys_clk;
	logic             sys_rst_n;
	logic [str_w-1:0] tx_string;
	logic [len_w-1:0] tx_length;
	logic             tx_req;
	logic             tx_busy;
	logic             tx_done;
	logic [str_w-1:0] rx_string;
	logic [len_w-1:0] rx_length;
	logic             rx_busy;
	logic             rx_done;
	logic             uart_rx_port;
	logic             uart_tx_port;

	logic             loopback; // Receive pin follows the transmit pin.
	logic             enc_line;
	integer           seed;
	int               err_cnt = 0;
	int               done_cnt = 0;   // tx_done pulses.
	int               rx_cnt = 0;     // rx_done pulses.
	int               line_total = 0; // Bytes decoded on uart_tx_port.
	int               line_expect = 0;
	int               frames_sent = 0;
	int               rx_expect = 0;
	logic [str_w-1:0] got_str;
	logic [len_w-1:0] got_len;
	logic [7:0]       pay [0:19];
	int               pay_len;
	logic [7:0]       frame_q [$];   // Bytes of the current frame on the line.
	logic [7:0]       tx_line_q [$];

	uart_string_top uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial sys_clk = 1'b0;
	always #(clk_ns / 2) sys_clk = ~sys_clk;

	assign uart_rx_port = loopback ? uart_tx_port : enc_line;

	always @(negedge sys_clk) begin
		if (tx_done)
			done_cnt <= done_cnt + 1;
		if (rx_done) begin
			rx_cnt <= rx_cnt + 1;
			got_str <= rx_string; // Result of the frame just closed.
			got_len <= rx_length;
			check_flag("rx_busy at rx_done", rx_busy, 1'b1);
		end
	end

	// Decodes every byte on the transmit pin, sampling mid-bit.
	initial begin : line_decoder
		logic [7:0] b;
		int i;
		forever begin
			@(negedge uart_tx_port);
			#(bit_ns / 2);
			if (uart_tx_port == 1'b0) begin
				for (i = 0; i < 8; i++) begin
					#(bit_ns);
					b[i] = uart_tx_port;
				end
				#(bit_ns);
				if (uart_tx_port) begin
					tx_line_q.push_back(b);
					line_total++;
				end
			end
		end
	end

	initial begin : watchdog
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		halt_run();
	end

	task automatic halt_run;
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_string(input string what, input logic [str_w-1:0] got,
			input logic [str_w-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			halt_run();
		end
	endtask

	task automatic check_length(input string what, input logic [len_w-1:0] got,
			input logic [len_w-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			halt_run();
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			halt_run();
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			halt_run();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			halt_run();
		end
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = 8'($random(seed));
		if (b == frame_mark)
			b = 8'h2a;
		return b;
	endfunction

	task automatic make_payload(input int len, input logic with_mark);
		int k;
		int p;
		pay_len = len;
		for (k = 0; k < len; k++)
			pay[k] = rand_byte();
		if (with_mark) begin
			p = rand_below(len - 1); // Never the final byte.
			pay[p] = frame_mark;
		end
	endtask

	task automatic build_frame(input logic stray);
		int k;
		frame_q.delete();
		if (stray) begin
			frame_q.push_back(frame_mark);
			frame_q.push_back(rand_byte()); // Lone mark, not an opening.
		end
		frame_q.push_back(frame_mark);
		frame_q.push_back(frame_mark);
		for (k = 0; k < pay_len; k++)
			frame_q.push_back(pay[k]);
		frame_q.push_back(frame_mark);
		frame_q.push_back(frame_mark);
	endtask

	// Receive rules applied to the line bytes of frame_q.
	task automatic model_receive(output logic [str_w-1:0] s, output logic [len_w-1:0] n);
		int st; // 0 idle, 1 open, 2 payload, 3 pending mark.
		logic [7:0] b;
		s = '0;
		n = '0;
		st = 0;
		foreach (frame_q[k]) begin
			b = frame_q[k];
			case (st)
				0: if (b == frame_mark) st = 1;
				1: st = (b == frame_mark) ? 2 : 0;
				2: begin
					if (b == frame_mark)
						st = 3;
					else
						append_payload(s, n, b);
				end
				default: begin
					if (b == frame_mark) begin
						st = 0; // Closing pair.
					end else begin
						append_payload(s, n, frame_mark);
						append_payload(s, n, b);
						st = 2;
					end
				end
			endcase
		end
	endtask

	task automatic append_payload(inout logic [str_w-1:0] s, inout logic [len_w-1:0] n,
			input logic [7:0] b);
		if (n < len_w'(str_bytes)) begin
			s[8*n +: 8] = b;
			n = n + len_w'(1);
		end
	endtask

	task automatic send_line_byte(input logic [7:0] b);
		int i;
		enc_line = 1'b0;
		repeat (clks_per_bit) @(negedge sys_clk);
		for (i = 0; i < 8; i++) begin
			enc_line = b[i];
			repeat (clks_per_bit) @(negedge sys_clk);
		end
		enc_line = 1'b1;
		repeat (clks_per_bit + 2) @(negedge sys_clk); // Stop bit and a short gap.
	endtask

	task automatic check_rx_frame;
		logic [str_w-1:0] exp_str;
		logic [len_w-1:0] exp_len;
		model_receive(exp_str, exp_len);
		while (rx_cnt != rx_expect)
			@(negedge sys_clk);
		check_string("rx_string", got_str, exp_str);
		check_length("rx_length", got_len, exp_len);
		check_flag("rx_busy after frame", rx_busy, 1'b0);
	endtask

	task automatic run_loopback_frame(input logic extra_req);
		int k;
		tx_line_q.delete();
		tx_string = '0;
		for (k = 0; k < pay_len; k++)
			tx_string[8*k +: 8] = pay[k];
		tx_length = len_w'(pay_len);
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		check_flag("tx_busy after request", tx_busy, 1'b1);
		frames_sent++;
		line_expect += frame_q.size();
		rx_expect++;
		tx_string = {4{$random(seed)}}; // Latched copy must be used from here.
		tx_length = len_w'($random(seed));
		if (extra_req) begin
			repeat (3 * clks_per_bit) @(negedge sys_clk);
			tx_req = 1'b1;
			repeat (2) @(negedge sys_clk);
			tx_req = 1'b0;
		end
		while (!tx_done)
			@(negedge sys_clk);
		check_count("decoded frame bytes", tx_line_q.size(), frame_q.size());
		for (k = 0; k < frame_q.size(); k++)
			check_byte("decoded line byte", tx_line_q[k], frame_q[k]);
		check_rx_frame();
		check_count("tx_done pulses", done_cnt, frames_sent);
	endtask

	task automatic run_encoded_frame;
		int k;
		rx_expect++;
		for (k = 0; k < frame_q.size(); k++)
			send_line_byte(frame_q[k]);
		check_rx_frame();
	endtask

	initial begin : stimulus
		int k;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		enc_line = 1'b1;
		loopback = 1'b1;
		seed = 32'h1aac;
		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_flag("tx_busy", tx_busy, 1'b0);
		check_flag("tx_done", tx_done, 1'b0);
		check_flag("rx_busy", rx_busy, 1'b0);
		check_flag("rx_done", rx_done, 1'b0);
		check_flag("uart_tx_port", uart_tx_port, 1'b1);

		for (k = 0; k < 20; k++) begin // Transmit format and loopback.
			make_payload(1 + rand_below(16), 1'b0);
			build_frame(1'b0);
			run_loopback_frame(1'b0);
		end

		loopback = 1'b0;
		for (k = 0; k < 4; k++) begin // Single marks inside the payload.
			make_payload(2 + rand_below(15), 1'b1);
			build_frame(k[0] == 1'b0);
			run_encoded_frame();
		end
		for (k = 0; k < 2; k++) begin // Longer than the buffer.
			make_payload(17 + rand_below(4), 1'b0);
			build_frame(1'b0);
			run_encoded_frame();
		end

		loopback = 1'b1;
		make_payload(1 + rand_below(16), 1'b0);
		build_frame(1'b0);
		run_loopback_frame(1'b1);
		repeat (4 * 10 * clks_per_bit) @(negedge sys_clk);
		check_flag("tx_busy after last frame", tx_busy, 1'b0);
		check_count("tx_done pulses", done_cnt, frames_sent);
		check_count("decoded line bytes", line_total, line_expect);

		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
